//--- sm83_bottom.f
+incdir+test
common/sm83_bottom_pkg.sv
verilog/wb_cmd_decode.sv
regfile/reg_pairs.sv
regfile/addr_incdec.sv
irq/irq_ctrl.sv
verilog/wb_readback.sv
verilog/sm83_bottom.sv
test/tb_sm83_bottom.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      := tb_sm83_bottom
FILELIST := sm83_bottom.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- test/tb_vectors.svh
// Columns are operation, offset, data, expected value and a run-time flag.
// The flag draws write data from $urandom, or takes the expected value from the model.
localparam logic [2:0] DO_WRITE = 3'd0;
localparam logic [2:0] DO_READ = 3'd1;
localparam logic [2:0] DO_STEP = 3'd2;	// Expected value is addr
localparam logic [2:0] DO_TRIG = 3'd3;	// Expected value is irq_pending
localparam logic [2:0] DO_SERVICE = 3'd4;	// Expected value is irq_ack

typedef struct packed {
	logic [2:0] op;
	logic [ADR_W-1:0] adr;
	logic [DATA_W-1:0] data;
	logic [DATA_W-1:0] exp;
	logic dyn;
} vec_t;

localparam int NUM_ROWS = 54;

localparam vec_t VECTORS [NUM_ROWS] = '{
	'{DO_READ, ADR_BC, 16'h0000, 16'h0000, 1'b0},	// Reset values
	'{DO_READ, ADR_DE, 16'h0000, 16'h0000, 1'b0},
	'{DO_READ, ADR_HL, 16'h0000, 16'h0000, 1'b0},
	'{DO_READ, ADR_SP, 16'h0000, 16'hFFFE, 1'b0},
	'{DO_READ, ADR_PC, 16'h0000, 16'h0000, 1'b0},
	'{DO_READ, ADR_IE, 16'h0000, 16'h0000, 1'b0},
	'{DO_READ, ADR_IF, 16'h0000, 16'h0000, 1'b0},
	'{DO_READ, ADR_STEP, 16'h0000, 16'h0000, 1'b0},
	'{DO_READ, ADR_SERVICE, 16'h0000, 16'h0000, 1'b0},
	'{DO_READ, ADR_ADDR, 16'h0000, 16'h0000, 1'b0},
	'{DO_WRITE, ADR_BC, 16'h1234, 16'h0000, 1'b0},	// Pair write and read back
	'{DO_READ, ADR_BC, 16'h0000, 16'h1234, 1'b0},
	'{DO_WRITE, ADR_DE, 16'h0000, 16'h0000, 1'b1},
	'{DO_READ, ADR_DE, 16'h0000, 16'h0000, 1'b1},
	'{DO_WRITE, ADR_HL, 16'h0000, 16'h0000, 1'b1},
	'{DO_READ, ADR_HL, 16'h0000, 16'h0000, 1'b1},
	'{DO_WRITE, ADR_SP, 16'hA5A5, 16'h0000, 1'b0},
	'{DO_READ, ADR_SP, 16'h0000, 16'hA5A5, 1'b0},
	'{DO_WRITE, ADR_PC, 16'h0000, 16'h0000, 1'b1},
	'{DO_READ, ADR_PC, 16'h0000, 16'h0000, 1'b1},
	'{DO_READ, ADR_IF, 16'h0000, 16'h0000, 1'b0},
	'{DO_READ, ADR_ADDR, 16'h0000, 16'h0000, 1'b0},
	// Step words carry the operation in bits 4:3 and the pair in bits 2:0
	'{DO_WRITE, ADR_BC, 16'hFFFF, 16'h0000, 1'b0},
	'{DO_STEP, ADR_STEP, 16'h0008, 16'hFFFF, 1'b0},	// Wrap up
	'{DO_READ, ADR_BC, 16'h0000, 16'h0000, 1'b0},
	'{DO_STEP, ADR_STEP, 16'h0010, 16'h0000, 1'b0},	// Wrap down
	'{DO_READ, ADR_BC, 16'h0000, 16'hFFFF, 1'b0},
	'{DO_STEP, ADR_STEP, 16'h0009, 16'h0000, 1'b1},
	'{DO_READ, ADR_DE, 16'h0000, 16'h0000, 1'b1},
	'{DO_STEP, ADR_STEP, 16'h0012, 16'h0000, 1'b1},
	'{DO_READ, ADR_HL, 16'h0000, 16'h0000, 1'b1},
	'{DO_STEP, ADR_STEP, 16'h000B, 16'hA5A5, 1'b0},
	'{DO_READ, ADR_SP, 16'h0000, 16'hA5A6, 1'b0},
	'{DO_STEP, ADR_STEP, 16'h0014, 16'h0000, 1'b1},
	'{DO_READ, ADR_PC, 16'h0000, 16'h0000, 1'b1},
	'{DO_STEP, ADR_STEP, 16'h0003, 16'hA5A6, 1'b0},	// Hold
	'{DO_READ, ADR_SP, 16'h0000, 16'hA5A6, 1'b0},
	'{DO_WRITE, ADR_IE, 16'h0026, 16'h0000, 1'b0},	// Lines 1, 2 and 5 enabled
	'{DO_TRIG, ADR_IF, 16'h00D0, 16'h0000, 1'b0},
	'{DO_READ, ADR_IF, 16'h0000, 16'h0000, 1'b0},
	'{DO_TRIG, ADR_IF, 16'h0027, 16'h0001, 1'b0},
	'{DO_READ, ADR_IF, 16'h0000, 16'h0026, 1'b0},
	'{DO_SERVICE, ADR_SERVICE, 16'h0000, 16'h0002, 1'b0},	// Lowest pending first
	'{DO_READ, ADR_PC, 16'h0000, 16'h0048, 1'b0},
	'{DO_READ, ADR_IF, 16'h0000, 16'h0024, 1'b0},
	'{DO_SERVICE, ADR_SERVICE, 16'h0000, 16'h0004, 1'b0},
	'{DO_READ, ADR_PC, 16'h0000, 16'h0050, 1'b0},
	'{DO_READ, ADR_IF, 16'h0000, 16'h0020, 1'b0},
	'{DO_SERVICE, ADR_SERVICE, 16'h0000, 16'h0020, 1'b0},
	'{DO_READ, ADR_PC, 16'h0000, 16'h0068, 1'b0},
	'{DO_READ, ADR_IF, 16'h0000, 16'h0000, 1'b0},
	'{DO_SERVICE, ADR_SERVICE, 16'h0000, 16'h0000, 1'b0},	// Nothing pending
	'{DO_READ, ADR_PC, 16'h0000, 16'h0068, 1'b0},
	'{DO_READ, ADR_IF, 16'h0000, 16'h0000, 1'b0}
};

//--- test/tb_sm83_bottom.sv
module tb_sm83_bottom;
	timeunit 1ns;
	timeprecision 100ps;
	import sm83_bottom_pkg::*;

	localparam int ACK_TIMEOUT = 20;	// Clocks
	localparam int IRQ_TIMEOUT = 20;
	localparam int SEED = 32;

	`include "tb_vectors.svh"

	logic clk;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [ADR_W-1:0] wb_adr;
	logic [DATA_W-1:0] wb_dat_i;
	logic [DATA_W-1:0] wb_dat_o;
	logic wb_ack;
	logic [DATA_W-1:0] addr;
	logic [IRQ_N-1:0] irq_trig;
	logic [IRQ_N-1:0] irq_ack;
	logic irq_pending;

	int errors;
	int timeouts;
	logic [DATA_W-1:0] shadow [10];	// Expected register contents by offset
	logic [IRQ_N-1:0] ack_seen;	// irq_ack during the last Wishbone ack
	logic [IRQ_N-1:0] ack_next;	// irq_ack in the cycle after it
	logic [DATA_W-1:0] addr_seen;	// Address bus during the last Wishbone ack

	sm83_bottom i_dut (.*);

	always #50 clk = ~clk;

	task automatic check_value(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Called on a falling edge, returns on a falling edge one idle cycle after ack
	task automatic bus_cycle(input logic we, input logic [ADR_W-1:0] adr,
			input logic [DATA_W-1:0] data, output logic [DATA_W-1:0] rdata);
		int n;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_i = data;
		n = 0;
		@(negedge clk);
		while (!wb_ack && n < ACK_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!wb_ack) begin
			timeouts++;
			$display("no Wishbone ack for offset %0d at %0t", adr, $time);
		end else begin
			check_value(DATA_W'(n), '0, "extra Wishbone wait states");
		end
		rdata = wb_dat_o;
		ack_seen = irq_ack;
		addr_seen = addr;
		@(negedge clk);	// Hold through the ack cycle
		check_value(DATA_W'(wb_ack), '0, "wb_ack one cycle after ack");
		ack_next = irq_ack;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		@(negedge clk);
	endtask

	task automatic pulse_irq(input logic [IRQ_N-1:0] lines, input logic level);
		int n;
		irq_trig = lines;
		@(negedge clk);
		irq_trig = '0;
		n = 0;
		while (irq_pending !== level && n < IRQ_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (irq_pending !== level) begin
			timeouts++;
			$display("irq_pending did not reach %0b at %0t", level, $time);
		end
	endtask

	task automatic model_write(input logic [ADR_W-1:0] adr, input logic [DATA_W-1:0] data);
		if (adr <= ADR_PC)
			shadow[adr] = data;
		else if (adr == ADR_IE || adr == ADR_IF)
			shadow[adr] = DATA_W'(data[IRQ_N-1:0]);	// Only the low byte exists
	endtask

	task automatic model_step(input logic [DATA_W-1:0] data);
		logic [ADR_W-1:0] sel;
		logic [DATA_W-1:0] old;
		sel = ADR_W'(data[2:0]);	// Pair codes match the pair offsets
		old = shadow[sel];
		shadow[ADR_ADDR] = old;
		case (incdec_op_t'(data[4:3]))
			OP_INC: shadow[sel] = old + 16'd1;
			OP_DEC: shadow[sel] = old - 16'd1;
			default: ;
		endcase
	endtask

	task automatic model_service();
		logic [IRQ_N-1:0] pend;
		logic found;
		pend = shadow[ADR_IF][IRQ_N-1:0] & shadow[ADR_IE][IRQ_N-1:0];
		found = 1'b0;
		for (int i = 0; i < IRQ_N; i++) begin
			if (pend[i] && !found) begin
				found = 1'b1;
				shadow[ADR_IF][i] = 1'b0;
				shadow[ADR_PC] = VEC_BASE + VEC_STEP * DATA_W'(i);
			end
		end
	endtask

	task automatic apply_row(input vec_t row, input int idx);
		logic [DATA_W-1:0] data;
		logic [DATA_W-1:0] exp;
		logic [DATA_W-1:0] got;
		string tag;
		data = (row.dyn && row.op == DO_WRITE) ? DATA_W'($urandom) : row.data;
		tag = $sformatf("row %0d offset %0d", idx, row.adr);
		case (row.op)
			DO_WRITE: begin
				bus_cycle(1'b1, row.adr, data, got);
				model_write(row.adr, data);
			end
			DO_READ: begin
				exp = row.dyn ? shadow[row.adr] : row.exp;
				bus_cycle(1'b0, row.adr, '0, got);
				check_value(got, exp, {tag, " read"});
			end
			DO_STEP: begin
				exp = row.dyn ? shadow[ADR_W'(data[2:0])] : row.exp;
				bus_cycle(1'b1, ADR_STEP, data, got);
				check_value(addr_seen, exp, {tag, " addr at step ack"});
				model_step(data);
			end
			DO_TRIG: begin
				pulse_irq(data[IRQ_N-1:0], row.exp[0]);
				check_value(DATA_W'(irq_pending), row.exp, {tag, " irq_pending"});
				shadow[ADR_IF] = shadow[ADR_IF] | (data & shadow[ADR_IE]);
			end
			DO_SERVICE: begin
				bus_cycle(1'b1, ADR_SERVICE, '0, got);
				check_value(DATA_W'(ack_seen), row.exp, {tag, " irq_ack"});
				check_value(DATA_W'(ack_next), '0, {tag, " irq_ack one cycle later"});
				model_service();
			end
			default: begin
				errors++;
				$display("unknown operation in row %0d", idx);
			end
		endcase
	endtask

	initial begin
		void'($urandom(SEED));
		clk = 1'b0;
		rst = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_i = '0;
		irq_trig = '0;
		errors = 0;
		timeouts = 0;
		ack_seen = '0;
		ack_next = '0;
		addr_seen = '0;
		for (int i = 0; i < 10; i++)
			shadow[i] = '0;
		shadow[ADR_SP] = SP_RESET;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_value(DATA_W'(irq_ack), '0, "irq_ack after reset");
		check_value(DATA_W'(irq_pending), '0, "irq_pending after reset");
		for (int i = 0; i < NUM_ROWS; i++)
			apply_row(VECTORS[i], i);
		$display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- verilog/sm83_bottom.sv
module sm83_bottom (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               wb_cyc,
	input  logic                               wb_stb,
	input  logic                               wb_we,
	input  logic [sm83_bottom_pkg::ADR_W-1:0]  wb_adr,
	input  logic [sm83_bottom_pkg::DATA_W-1:0] wb_dat_i,
	output logic [sm83_bottom_pkg::DATA_W-1:0] wb_dat_o,
	output logic                               wb_ack,
	output logic [sm83_bottom_pkg::DATA_W-1:0] addr,	// External address bus
	input  logic [sm83_bottom_pkg::IRQ_N-1:0]  irq_trig,
	output logic [sm83_bottom_pkg::IRQ_N-1:0]  irq_ack,
	output logic                               irq_pending
);
	import sm83_bottom_pkg::*;

	// Decoded host commands
	logic pair_we;
	pair_sel_t pair_wsel;
	logic step_go;
	pair_sel_t step_sel;
	incdec_op_t step_op;
	logic ie_we;
	logic if_we;
	logic service_go;
	logic [DATA_W-1:0] wdata;
	logic [ADR_W-1:0] rd_adr;

	// Register file and incrementer
	logic [DATA_W-1:0] pair_q;
	logic [DATA_W-1:0] bc;
	logic [DATA_W-1:0] de;
	logic [DATA_W-1:0] hl;
	logic [DATA_W-1:0] sp;
	logic [DATA_W-1:0] pc;
	logic incdec_we;
	logic [DATA_W-1:0] incdec_value;

	// Interrupt side
	logic [IRQ_N-1:0] ie;
	logic [IRQ_N-1:0] iflag;
	logic pc_load;
	logic [DATA_W-1:0] pc_vector;

	wb_cmd_decode i_wb_cmd_decode (.*);

	reg_pairs i_reg_pairs (.*);

	addr_incdec i_addr_incdec (.*);

	irq_ctrl i_irq_ctrl (.*);

	wb_readback i_wb_readback (.*);

endmodule

//--- verilog/wb_readback.sv
module wb_readback (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               wb_cyc,
	input  logic                               wb_stb,
	input  logic [sm83_bottom_pkg::ADR_W-1:0]  rd_adr,
	input  logic [sm83_bottom_pkg::DATA_W-1:0] bc,
	input  logic [sm83_bottom_pkg::DATA_W-1:0] de,
	input  logic [sm83_bottom_pkg::DATA_W-1:0] hl,
	input  logic [sm83_bottom_pkg::DATA_W-1:0] sp,
	input  logic [sm83_bottom_pkg::DATA_W-1:0] pc,
	input  logic [sm83_bottom_pkg::IRQ_N-1:0]  ie,
	input  logic [sm83_bottom_pkg::IRQ_N-1:0]  iflag,
	input  logic [sm83_bottom_pkg::DATA_W-1:0] addr,
	output logic                               wb_ack,
	output logic [sm83_bottom_pkg::DATA_W-1:0] wb_dat_o
);
	import sm83_bottom_pkg::*;

	logic [DATA_W-1:0] rd_mux;

	always_comb begin
		case (rd_adr)
			ADR_BC: rd_mux = bc;
			ADR_DE: rd_mux = de;
			ADR_HL: rd_mux = hl;
			ADR_SP: rd_mux = sp;
			ADR_PC: rd_mux = pc;
			ADR_IE: rd_mux = DATA_W'(ie);	// Zero extended
			ADR_IF: rd_mux = DATA_W'(iflag);
			ADR_ADDR: rd_mux = addr;
			default: rd_mux = '0;	// STEP, SERVICE, unmapped
		endcase
	end

	// Single wait state, ack high for one clock
	always_ff @(posedge clk) begin
		if (rst)
			wb_ack <= 1'b0;
		else
			wb_ack <= wb_cyc & wb_stb & ~wb_ack;
	end

	// Captured at the ack edge
	always_ff @(posedge clk) begin
		wb_dat_o <= rd_mux;
	end

endmodule

//--- irq/irq_ctrl.sv
module irq_ctrl (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               ie_we,
	input  logic                               if_we,
	input  logic                               service_go,
	input  logic [sm83_bottom_pkg::DATA_W-1:0] wdata,
	input  logic [sm83_bottom_pkg::IRQ_N-1:0]  irq_trig,
	output logic [sm83_bottom_pkg::IRQ_N-1:0]  ie,
	output logic [sm83_bottom_pkg::IRQ_N-1:0]  iflag,
	output logic                               irq_pending,
	output logic [sm83_bottom_pkg::IRQ_N-1:0]  irq_ack,
	output logic                               pc_load,
	output logic [sm83_bottom_pkg::DATA_W-1:0] pc_vector
);
	import sm83_bottom_pkg::*;

	logic [IRQ_N-1:0] pend_vec;
	logic [IRQ_N-1:0] grant;	// One-hot winner, zero when idle
	logic [IRQ_IDX_W-1:0] grant_idx;
	logic [IRQ_N-1:0] ie_next;
	logic [IRQ_N-1:0] if_next;

	assign pend_vec = iflag & ie;

	// Lowest line has the highest priority
	always_comb begin
		grant_idx = '0;
		for (int i = IRQ_N - 1; i >= 0; i--) begin
			if (pend_vec[i])
				grant_idx = IRQ_IDX_W'(i);
		end
	end

	assign pc_load = service_go & (|pend_vec);
	assign grant = pc_load ? (IRQ_N'(1) << grant_idx) : '0;
	assign pc_vector = VEC_BASE + VEC_STEP * DATA_W'(grant_idx);

	assign ie_next = ie_we ? wdata[IRQ_N-1:0] : ie;

	// Trigger ORed in last so it beats a clear of the same bit
	assign if_next = ((if_we ? wdata[IRQ_N-1:0] : iflag) & ~grant) | (irq_trig & ie);

	always_ff @(posedge clk) begin
		if (rst) begin
			ie <= '0;
			iflag <= '0;
			irq_pending <= 1'b0;
			irq_ack <= '0;
		end else begin
			ie <= ie_next;
			iflag <= if_next;
			irq_pending <= |(if_next & ie_next);	// Tracks IF & IE without lag
			irq_ack <= grant;
		end
	end

	a_ack_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(irq_ack))
		else $error("irq_ack has more than one bit set");

	a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
		|irq_ack |=> irq_ack == '0)
		else $error("irq_ack held longer than one cycle");

endmodule

//--- regfile/addr_incdec.sv
module addr_incdec (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               step_go,
	input  sm83_bottom_pkg::incdec_op_t        step_op,
	input  logic [sm83_bottom_pkg::DATA_W-1:0] pair_q,	// Pre-value of the selected pair
	output logic [sm83_bottom_pkg::DATA_W-1:0] addr,
	output logic                               incdec_we,
	output logic [sm83_bottom_pkg::DATA_W-1:0] incdec_value
);
	import sm83_bottom_pkg::*;

	logic [DATA_W-1:0] delta;

	// One adder, minus one is all ones and wraps mod 2^16
	always_comb begin
		case (step_op)
			OP_INC: delta = DATA_W'(1);
			OP_DEC: delta = '1;
			default: delta = '0;
		endcase
	end

	assign incdec_value = pair_q + delta;
	assign incdec_we = step_go && (step_op != OP_HOLD);

	// Address bus shows the value before the step
	always_ff @(posedge clk) begin
		if (rst)
			addr <= '0;
		else if (step_go)
			addr <= pair_q;
	end

	a_op_known: assert property (@(posedge clk) disable iff (rst)
		step_go |-> (step_op == OP_HOLD || step_op == OP_INC || step_op == OP_DEC))
		else $error("undefined increment/decrement code");

endmodule

//--- regfile/reg_pairs.sv
module reg_pairs (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               pair_we,	// Host write
	input  sm83_bottom_pkg::pair_sel_t         pair_wsel,
	input  logic [sm83_bottom_pkg::DATA_W-1:0] wdata,
	input  sm83_bottom_pkg::pair_sel_t         step_sel,	// Pair seen by the incrementer
	input  logic                               incdec_we,
	input  logic [sm83_bottom_pkg::DATA_W-1:0] incdec_value,
	input  logic                               pc_load,	// Interrupt vector load
	input  logic [sm83_bottom_pkg::DATA_W-1:0] pc_vector,
	output logic [sm83_bottom_pkg::DATA_W-1:0] pair_q,
	output logic [sm83_bottom_pkg::DATA_W-1:0] bc,
	output logic [sm83_bottom_pkg::DATA_W-1:0] de,
	output logic [sm83_bottom_pkg::DATA_W-1:0] hl,
	output logic [sm83_bottom_pkg::DATA_W-1:0] sp,
	output logic [sm83_bottom_pkg::DATA_W-1:0] pc
);
	import sm83_bottom_pkg::*;

	// Operand for the incrementer, also the next address
	always_comb begin
		case (step_sel)
			PAIR_BC: pair_q = bc;
			PAIR_DE: pair_q = de;
			PAIR_HL: pair_q = hl;
			PAIR_SP: pair_q = sp;
			PAIR_PC: pair_q = pc;
			default: pair_q = '0;
		endcase
	end

	// Later assignments win, so a vector load overrides a PC step
	always_ff @(posedge clk) begin
		if (rst) begin
			bc <= '0;
			de <= '0;
			hl <= '0;
			sp <= SP_RESET;
			pc <= '0;
		end else begin
			if (pair_we) begin
				case (pair_wsel)
					PAIR_BC: bc <= wdata;
					PAIR_DE: de <= wdata;
					PAIR_HL: hl <= wdata;
					PAIR_SP: sp <= wdata;
					PAIR_PC: pc <= wdata;
					default: ;
				endcase
			end
			if (incdec_we) begin
				case (step_sel)
					PAIR_BC: bc <= incdec_value;
					PAIR_DE: de <= incdec_value;
					PAIR_HL: hl <= incdec_value;
					PAIR_SP: sp <= incdec_value;
					PAIR_PC: pc <= incdec_value;
					default: ;	// Unknown pair, nothing to write back
				endcase
			end
			if (pc_load)
				pc <= pc_vector;
		end
	end

	// Host PC write and vector load come from different commands
	a_pc_sources: assert property (@(posedge clk) disable iff (rst)
		!(pc_load && pair_we && pair_wsel == PAIR_PC))
		else $error("PC written by host and interrupt in one cycle");

endmodule

//--- verilog/wb_cmd_decode.sv
module wb_cmd_decode (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               wb_cyc,
	input  logic                               wb_stb,
	input  logic                               wb_we,
	input  logic [sm83_bottom_pkg::ADR_W-1:0]  wb_adr,
	input  logic                               wb_ack,	// Registered ack fed back
	input  logic [sm83_bottom_pkg::DATA_W-1:0] wb_dat_i,
	output logic                               pair_we,
	output sm83_bottom_pkg::pair_sel_t         pair_wsel,
	output logic                               step_go,
	output sm83_bottom_pkg::pair_sel_t         step_sel,
	output sm83_bottom_pkg::incdec_op_t        step_op,
	output logic                               ie_we,
	output logic                               if_we,
	output logic                               service_go,
	output logic [sm83_bottom_pkg::DATA_W-1:0] wdata,
	output logic [sm83_bottom_pkg::ADR_W-1:0]  rd_adr
);
	import sm83_bottom_pkg::*;

	logic cmd_valid;
	logic cmd_wr;

	assign cmd_valid = wb_cyc & wb_stb & ~wb_ack;	// First cycle of a transfer
	assign cmd_wr = cmd_valid & wb_we;

	assign wdata = wb_dat_i;
	assign step_sel = pair_sel_t'(wb_dat_i[2:0]);	// Step word carries pair in 2:0
	assign step_op = incdec_op_t'(wb_dat_i[4:3]);	// and operation in 4:3

	// Writes and idle cycles point the read mux at an unmapped offset
	assign rd_adr = (cmd_valid & ~wb_we) ? wb_adr : '1;

	always_comb begin
		pair_we = 1'b0;
		pair_wsel = PAIR_BC;
		step_go = 1'b0;
		ie_we = 1'b0;
		if_we = 1'b0;
		service_go = 1'b0;
		case (wb_adr)
			ADR_BC: begin
				pair_we = cmd_wr;
				pair_wsel = PAIR_BC;
			end
			ADR_DE: begin
				pair_we = cmd_wr;
				pair_wsel = PAIR_DE;
			end
			ADR_HL: begin
				pair_we = cmd_wr;
				pair_wsel = PAIR_HL;
			end
			ADR_SP: begin
				pair_we = cmd_wr;
				pair_wsel = PAIR_SP;
			end
			ADR_PC: begin
				pair_we = cmd_wr;
				pair_wsel = PAIR_PC;
			end
			ADR_IE: ie_we = cmd_wr;
			ADR_IF: if_we = cmd_wr;
			ADR_STEP: step_go = cmd_wr;
			ADR_SERVICE: service_go = cmd_wr;
			default: ;	// ADDR and unmapped writes are dropped
		endcase
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (rst)
		$onehot0({pair_we, step_go, ie_we, if_we, service_go}))
		else $error("more than one command strobe active");

	// Master must hold the request until the slave answers
	a_stb_held: assert property (@(posedge clk) disable iff (rst)
		cmd_valid |=> wb_stb && wb_ack && $stable(wb_adr) && $stable(wb_we)
			&& $stable(wb_dat_i))
		else $error("Wishbone request changed before ack");

endmodule

//--- common/sm83_bottom_pkg.sv
package sm83_bottom_pkg;

	localparam int DATA_W = 16;	// Register pair and Wishbone data width
	localparam int ADR_W = 4;	// Wishbone word address width
	localparam int IRQ_N = 8;	// Interrupt lines
	localparam int IRQ_IDX_W = $clog2(IRQ_N);

	// Host register map, word addresses
	localparam logic [ADR_W-1:0] ADR_BC = 4'd0;
	localparam logic [ADR_W-1:0] ADR_DE = 4'd1;
	localparam logic [ADR_W-1:0] ADR_HL = 4'd2;
	localparam logic [ADR_W-1:0] ADR_SP = 4'd3;
	localparam logic [ADR_W-1:0] ADR_PC = 4'd4;
	localparam logic [ADR_W-1:0] ADR_IE = 4'd5;
	localparam logic [ADR_W-1:0] ADR_IF = 4'd6;
	localparam logic [ADR_W-1:0] ADR_STEP = 4'd7;	// Write only
	localparam logic [ADR_W-1:0] ADR_SERVICE = 4'd8;	// Write only
	localparam logic [ADR_W-1:0] ADR_ADDR = 4'd9;	// Read only, external address bus

	typedef enum logic [2:0] {
		PAIR_BC,
		PAIR_DE,
		PAIR_HL,
		PAIR_SP,
		PAIR_PC
	} pair_sel_t;

	typedef enum logic [1:0] {
		OP_HOLD,
		OP_INC,
		OP_DEC
	} incdec_op_t;

	localparam logic [DATA_W-1:0] SP_RESET = 16'hFFFE;

	// Interrupt n jumps to VEC_BASE + n * VEC_STEP
	localparam logic [DATA_W-1:0] VEC_BASE = 16'h0040;
	localparam logic [DATA_W-1:0] VEC_STEP = 16'd8;

endpackage
